// File: hw/rv_core_pkg.sv
package rv_core_pkg;

	// ====================
	// Widths
	// ====================

	localparam int XLEN = 32;
	localparam int N_REGS = 32;
	localparam logic [XLEN-1:0] RESET_PC = '0;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [$clog2(N_REGS)-1:0] regaddr_t;
	typedef logic [31:0] instr_t;

	// ====================
	// Opcodes and functs
	// ====================

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// Alternate funct7 selects SUB and SRA/SRAI
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// ====================
	// Control encodings
	// ====================

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_e;

	typedef enum logic [0:0] {SRC_B_RS2, SRC_B_IMM} src_b_e;

	// Decode to execute register
	typedef struct packed {
		logic     valid;
		regaddr_t rs1;
		regaddr_t rs2;
		regaddr_t rd;
		alu_op_e  alu_op;
		src_a_e   src_a;
		src_b_e   src_b;
		word_t    imm;
		word_t    pc;
	} dx_t;

	// Write-back register, also the observation port
	typedef struct packed {
		logic     valid;
		regaddr_t rd;
		word_t    data;
	} wb_t;

endpackage

// File: hw/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
	input  rv_core_pkg::alu_op_e op_i,
	input  rv_core_pkg::word_t   a_i,
	input  rv_core_pkg::word_t   b_i,
	output rv_core_pkg::word_t   result_o
);
	import rv_core_pkg::*;

	localparam int SHAMT_W = $clog2(XLEN);

	logic [SHAMT_W-1:0] shamt;
	logic               lt_signed;
	logic               lt_unsigned;

	// Shift amount is the low bits of b only
	assign shamt       = b_i[SHAMT_W-1:0];
	assign lt_signed   = $signed(a_i) < $signed(b_i);
	assign lt_unsigned = a_i < b_i;

	always_comb begin
		unique case (op_i)
			ALU_ADD: begin
				result_o = a_i + b_i;
			end
			ALU_SUB: begin
				result_o = a_i - b_i;
			end
			ALU_SLL: begin
				result_o = a_i << shamt;
			end
			ALU_SLT: begin
				result_o = {{(XLEN-1){1'b0}}, lt_signed};
			end
			ALU_SLTU: begin
				result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
			end
			ALU_XOR: begin
				result_o = a_i ^ b_i;
			end
			ALU_SRL: begin
				result_o = a_i >> shamt;
			end
			ALU_SRA: begin
				result_o = word_t'($signed(a_i) >>> shamt);
			end
			ALU_OR: begin
				result_o = a_i | b_i;
			end
			ALU_AND: begin
				result_o = a_i & b_i;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_core_pkg::regaddr_t raddr1_i,
	input  rv_core_pkg::regaddr_t raddr2_i,
	output rv_core_pkg::word_t    rdata1_o,
	output rv_core_pkg::word_t    rdata2_o,
	input  rv_core_pkg::wb_t      wb_i
);
	import rv_core_pkg::*;

	// x0 has no storage
	word_t regs [1:N_REGS-1];

	// ====================
	// Write port
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < N_REGS; i++)
				regs[i] <= '0;
		end else if (wb_i.valid && wb_i.rd != '0) begin
			regs[wb_i.rd] <= wb_i.data;
		end
	end

	// ====================
	// Read ports
	// ====================

	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

	// Decode and execute together keep x0 writes out of the write-back
	a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wb_i.valid |-> wb_i.rd != '0);

endmodule

// File: hw/rv_decode.sv
`timescale 1ns/1ns

module rv_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid_i,
	input  rv_core_pkg::instr_t instr_i,
	output rv_core_pkg::dx_t    dx_o,
	output logic                illegal_o
);
	import rv_core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_u;
	word_t      pc_q;
	dx_t        dx_nxt;
	logic       legal;

	// Shared funct3 mapping for OP and OP-IMM
	function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		unique case (f3)
			F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
			F3_SLL:     op = ALU_SLL;
			F3_SLT:     op = ALU_SLT;
			F3_SLTU:    op = ALU_SLTU;
			F3_XOR:     op = ALU_XOR;
			F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
			F3_OR:      op = ALU_OR;
			default:    op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];
	assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_u  = {instr_i[31:12], 12'b0};

	always_comb begin
		dx_nxt        = '0;
		dx_nxt.rs1    = instr_i[19:15];
		dx_nxt.rs2    = instr_i[24:20];
		dx_nxt.rd     = instr_i[11:7];
		dx_nxt.alu_op = ALU_ADD;
		dx_nxt.src_a  = SRC_A_RS1;
		dx_nxt.src_b  = SRC_B_RS2;
		dx_nxt.imm    = imm_i;
		dx_nxt.pc     = pc_q;
		legal         = 1'b0;
		unique case (opcode)
			OPC_OP: begin
				legal = (funct7 == F7_BASE) || (funct7 == F7_ALT &&
					(funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
				dx_nxt.alu_op = alu_from_funct3(funct3, funct7 == F7_ALT);
			end
			OPC_OP_IMM: begin
				// Only shifts carry funct7; ADDI bit 30 is immediate
				if (funct3 == F3_SLL) begin
					legal = funct7 == F7_BASE;
				end else if (funct3 == F3_SRL_SRA) begin
					legal = funct7 == F7_BASE || funct7 == F7_ALT;
				end else begin
					legal = 1'b1;
				end
				dx_nxt.alu_op = alu_from_funct3(funct3,
					funct3 == F3_SRL_SRA && funct7 == F7_ALT);
				dx_nxt.src_b = SRC_B_IMM;
			end
			OPC_LUI: begin
				legal        = 1'b1;
				dx_nxt.src_a = SRC_A_ZERO;
				dx_nxt.src_b = SRC_B_IMM;
				dx_nxt.imm   = imm_u;
			end
			OPC_AUIPC: begin
				legal        = 1'b1;
				dx_nxt.src_a = SRC_A_PC;
				dx_nxt.src_b = SRC_B_IMM;
				dx_nxt.imm   = imm_u;
			end
			default: legal = 1'b0;
		endcase
		dx_nxt.valid = instr_valid_i && legal;
		// Bubbles never write back
		if (!dx_nxt.valid)
			dx_nxt.rd = '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q      <= RESET_PC;
			dx_o      <= '0;
			illegal_o <= 1'b0;
		end else begin
			dx_o      <= dx_nxt;
			illegal_o <= instr_valid_i && !legal;
			if (instr_valid_i)
				pc_q <= pc_q + 32'd4;
		end
	end

	a_valid_or_illegal: assert property (@(posedge clk) disable iff (!rst_n)
		!(dx_o.valid && illegal_o));

endmodule

// File: hw/rv_execute.sv
`timescale 1ns/1ns

module rv_execute (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_core_pkg::dx_t      dx_i,
	output rv_core_pkg::regaddr_t raddr1_o,
	output rv_core_pkg::regaddr_t raddr2_o,
	input  rv_core_pkg::word_t    rdata1_i,
	input  rv_core_pkg::word_t    rdata2_i,
	output rv_core_pkg::wb_t      wb_o
);
	import rv_core_pkg::*;

	word_t rs1_val;
	word_t rs2_val;
	word_t op_a;
	word_t op_b;
	word_t alu_result;
	logic  hit1;
	logic  hit2;

	assign raddr1_o = dx_i.rs1;
	assign raddr2_o = dx_i.rs2;

	// ====================
	// Bypass
	// ====================

	// Previous result is not in the register file yet
	assign hit1 = wb_o.valid && dx_i.rs1 != '0 && wb_o.rd == dx_i.rs1;
	assign hit2 = wb_o.valid && dx_i.rs2 != '0 && wb_o.rd == dx_i.rs2;

	assign rs1_val = hit1 ? wb_o.data : rdata1_i;
	assign rs2_val = hit2 ? wb_o.data : rdata2_i;

	// ====================
	// Operand select
	// ====================

	always_comb begin
		unique case (dx_i.src_a)
			SRC_A_RS1: op_a = rs1_val;
			SRC_A_PC:  op_a = dx_i.pc;
			default:   op_a = '0;
		endcase
		op_b = (dx_i.src_b == SRC_B_IMM) ? dx_i.imm : rs2_val;
	end

	rv_alu alu0 (
		.op_i     (dx_i.alu_op),
		.a_i      (op_a),
		.b_i      (op_b),
		.result_o (alu_result)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_o <= '0;
		end else begin
			wb_o.valid <= dx_i.valid && dx_i.rd != '0;
			wb_o.rd    <= dx_i.rd;
			wb_o.data  <= alu_result;
		end
	end

	a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		wb_o.valid |-> wb_o.rd != '0);

endmodule

// File: hw/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid_i,
	input  rv_core_pkg::instr_t instr_i,
	output rv_core_pkg::wb_t    wb_o,
	output logic                illegal_o
);
	import rv_core_pkg::*;

	dx_t      dx;
	regaddr_t raddr1;
	regaddr_t raddr2;
	word_t    rdata1;
	word_t    rdata2;

	rv_decode decode0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.dx_o          (dx),
		.illegal_o     (illegal_o)
	);

	// Write-back port doubles as the observation output
	rv_regfile regfile0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.wb_i     (wb_o)
	);

	rv_execute execute0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.dx_i     (dx),
		.raddr1_o (raddr1),
		.raddr2_o (raddr2),
		.rdata1_i (rdata1),
		.rdata2_i (rdata2),
		.wb_o     (wb_o)
	);

endmodule

// File: tests/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;
	import rv_core_pkg::*;

	localparam int MAX_ROWS    = 40;
	localparam int N_GRPS      = 6;
	localparam int DRAIN_LIMIT = 10;
	localparam logic [6:0] OP_R     = 7'b0110011;
	localparam logic [6:0] OP_I     = 7'b0010011;
	localparam logic [6:0] OP_LUI   = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;

	typedef struct {
		instr_t     instr;
		logic       exp_wb;
		logic [4:0] rd;
		word_t      data;
		logic       exp_ill;
		logic       chain;
		int         grp;
	} row_t;

	typedef struct {
		int row;
		int acc;
	} pend_t;

	logic   clk = 1'b0;
	logic   rst_n;
	logic   instr_valid;
	instr_t instr;
	wb_t    wb;
	logic   illegal;

	row_t  rows [MAX_ROWS];
	pend_t pend_q [$];
	string grp_name [N_GRPS];
	int    grp_left [N_GRPS];
	int    grp_err [N_GRPS];
	int    n_rows = 0;
	int    cur_grp = -1;
	int    cyc = 0;
	int    checks = 0;
	int    errors = 0;
	logic  link = 1'b0;

	always #5 clk = ~clk;

	rv_core_top dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid_i (instr_valid),
		.instr_i       (instr),
		.wb_o          (wb),
		.illegal_o     (illegal)
	);

	// ====================
	// Encoding helpers
	// ====================

	function automatic instr_t encode_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_R};
	endfunction

	function automatic instr_t encode_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, OP_I};
	endfunction

	function automatic instr_t encode_u(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	task automatic start_group(input string name);
		cur_grp++;
		grp_name[cur_grp] = name;
		grp_left[cur_grp] = 0;
		grp_err[cur_grp] = 0;
	endtask

	task automatic add_row(input instr_t w, input logic has_wb, input logic [4:0] rd,
			input word_t data, input logic has_ill);
		rows[n_rows] = '{w, has_wb, rd, data, has_ill, link, cur_grp};
		grp_left[cur_grp]++;
		n_rows++;
	endtask

	// ====================
	// Stimulus table
	// ====================

	// Row n is accepted at PC 4*n
	task automatic build_table();
		start_group("register-immediate ALU");
		add_row(encode_i(12'hFFB, 5'd0, 3'd0, 5'd1), 1'b1, 5'd1, 32'hFFFFFFFB, 1'b0);
		add_row(encode_i(12'd100, 5'd0, 3'd0, 5'd2), 1'b1, 5'd2, 32'h00000064, 1'b0);
		add_row(encode_i(12'd1, 5'd1, 3'd2, 5'd4), 1'b1, 5'd4, 32'h00000001, 1'b0);
		add_row(encode_i(12'd1, 5'd1, 3'd3, 5'd5), 1'b1, 5'd5, 32'h00000000, 1'b0);
		add_row(encode_i(12'h0F0, 5'd2, 3'd4, 5'd7), 1'b1, 5'd7, 32'h00000094, 1'b0);
		add_row(encode_i(12'hF00, 5'd2, 3'd6, 5'd8), 1'b1, 5'd8, 32'hFFFFFF64, 1'b0);
		add_row(encode_i(12'h0FF, 5'd1, 3'd7, 5'd9), 1'b1, 5'd9, 32'h000000FB, 1'b0);
		add_row(encode_i(12'h004, 5'd1, 3'd1, 5'd10), 1'b1, 5'd10, 32'hFFFFFFB0, 1'b0);
		add_row(encode_i(12'h004, 5'd1, 3'd5, 5'd11), 1'b1, 5'd11, 32'h0FFFFFFF, 1'b0);
		add_row(encode_i(12'h401, 5'd1, 3'd5, 5'd12), 1'b1, 5'd12, 32'hFFFFFFFD, 1'b0);
		start_group("register-register ALU");
		add_row(encode_r(7'h20, 5'd7, 5'd2, 3'd0, 5'd14), 1'b1, 5'd14, 32'hFFFFFFD0, 1'b0);
		add_row(encode_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd16), 1'b1, 5'd16, 32'h00000001, 1'b0);
		add_row(encode_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd17), 1'b1, 5'd17, 32'h00000000, 1'b0);
		add_row(encode_r(7'h00, 5'd4, 5'd1, 3'd5, 5'd19), 1'b1, 5'd19, 32'h7FFFFFFD, 1'b0);
		add_row(encode_r(7'h20, 5'd4, 5'd1, 3'd5, 5'd20), 1'b1, 5'd20, 32'hFFFFFFFD, 1'b0);
		add_row(encode_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd18), 1'b1, 5'd18, 32'hFFFFFF9F, 1'b0);
		add_row(encode_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd13), 1'b1, 5'd13, 32'h0000005F, 1'b0);
		add_row(encode_r(7'h00, 5'd4, 5'd2, 3'd1, 5'd15), 1'b1, 5'd15, 32'h000000C8, 1'b0);
		add_row(encode_r(7'h00, 5'd9, 5'd2, 3'd6, 5'd21), 1'b1, 5'd21, 32'h000000FF, 1'b0);
		add_row(encode_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd22), 1'b1, 5'd22, 32'h00000060, 1'b0);
		// Back-to-back chain through x23..x26
		start_group("dependent chain");
		add_row(encode_i(12'd7, 5'd0, 3'd0, 5'd23), 1'b1, 5'd23, 32'h00000007, 1'b0);
		link = 1'b1;
		add_row(encode_r(7'h00, 5'd23, 5'd23, 3'd0, 5'd23), 1'b1, 5'd23, 32'h0000000E, 1'b0);
		add_row(encode_i(12'd2, 5'd23, 3'd1, 5'd24), 1'b1, 5'd24, 32'h00000038, 1'b0);
		add_row(encode_r(7'h20, 5'd24, 5'd23, 3'd0, 5'd25), 1'b1, 5'd25, 32'hFFFFFFD6, 1'b0);
		add_row(encode_r(7'h00, 5'd24, 5'd25, 3'd0, 5'd26), 1'b1, 5'd26, 32'h0000000E, 1'b0);
		link = 1'b0;
		start_group("x0 writes and reads");
		add_row(encode_i(12'd123, 5'd0, 3'd0, 5'd0), 1'b0, 5'd0, 32'h0, 1'b0);
		link = 1'b1;
		add_row(encode_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0), 1'b0, 5'd0, 32'h0, 1'b0);
		add_row(encode_r(7'h00, 5'd2, 5'd0, 3'd0, 5'd27), 1'b1, 5'd27, 32'h00000064, 1'b0);
		link = 1'b0;
		start_group("LUI and AUIPC");
		add_row(encode_u(20'h12345, 5'd29, OP_LUI), 1'b1, 5'd29, 32'h12345000, 1'b0);
		add_row(encode_u(20'h00001, 5'd30, OP_AUIPC), 1'b1, 5'd30, 32'h00001074, 1'b0);
		start_group("illegal instructions");
		add_row(32'h0FF0000F, 1'b0, 5'd0, 32'h0, 1'b1);
		add_row(32'h0000007F, 1'b0, 5'd0, 32'h0, 1'b1);
		add_row(encode_u(20'h00000, 5'd31, OP_AUIPC), 1'b1, 5'd31, 32'h00000080, 1'b0);
	endtask

	// ====================
	// Checking
	// ====================

	task automatic compare(input string name, input word_t got, input word_t exp, input int g);
		checks++;
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
			if (g >= 0)
				grp_err[g]++;
		end
	endtask

	// illegal_o belongs to the row accepted one edge ago, wb_o to two edges ago
	task automatic check_outputs();
		logic exp_ill;
		int   ill_grp;
		row_t r;
		exp_ill = 1'b0;
		ill_grp = -1;
		foreach (pend_q[i]) begin
			if (pend_q[i].acc == cyc - 1) begin
				exp_ill = rows[pend_q[i].row].exp_ill;
				ill_grp = rows[pend_q[i].row].grp;
			end
		end
		compare("illegal_o", {31'b0, illegal}, {31'b0, exp_ill}, ill_grp);
		if (pend_q.size() != 0 && pend_q[0].acc == cyc - 2) begin
			r = rows[pend_q[0].row];
			compare("wb_o.valid", {31'b0, wb.valid}, {31'b0, r.exp_wb}, r.grp);
			if (r.exp_wb) begin
				compare("wb_o.rd", {27'b0, wb.rd}, {27'b0, r.rd}, r.grp);
				compare("wb_o.data", wb.data, r.data, r.grp);
			end
			void'(pend_q.pop_front());
			grp_left[r.grp]--;
			if (grp_left[r.grp] == 0)
				$display("group %0d %s: %0d mismatches", r.grp + 1, grp_name[r.grp],
					grp_err[r.grp]);
		end else begin
			compare("wb_o.valid", {31'b0, wb.valid}, 32'b0, -1);
		end
	endtask

	// Check at the falling edge, then drive the next slot
	task automatic tick(input logic v, input int r);
		pend_t p;
		@(negedge clk);
		check_outputs();
		instr_valid = v;
		instr = v ? rows[r].instr : '0;
		if (v) begin
			p.row = r;
			p.acc = cyc;
			pend_q.push_back(p);
		end
		cyc++;
	endtask

	initial begin
		int gap;
		int t;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		void'($urandom(98));
		build_table();
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_rows; i++) begin
			if (!rows[i].chain) begin
				gap = $urandom % 3;
				repeat (gap) tick(1'b0, 0);
			end
			tick(1'b1, i);
		end
		t = 0;
		while (pend_q.size() != 0 && t < DRAIN_LIMIT) begin
			tick(1'b0, 0);
			t++;
		end
		if (pend_q.size() != 0) begin
			$display("Timeout: %0d instructions never reached write-back", pend_q.size());
			$display("ERRORS FOUND");
		end else begin
			$display("checks %0d, errors %0d", checks, errors);
			if (errors == 0)
				$display("NO ERRORS");
			else
				$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: vlog.f
hw/rv_core_pkg.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_core_top.sv
tests/tb_rv_core.sv

// File: Makefile
TOP = tb_rv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module $(TOP) -f vlog.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
